/* Makefile */
TOP := tb_timer_unit

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* filelist.f */
timer_pkg.sv
timer_counter.sv
timer_ref_sync.sv
timer_channel.sv
timer_bus.sv
timer_unit.sv
timer_assertions.sv
tb_timer_unit.sv

/* tb_timer_unit.sv */
module tb_timer_unit import timer_pkg::*; ();

   typedef enum logic [2:0] {
      OP_WRITE,
      OP_READ,        // read and compare with exp
      OP_READ_MAX,    // read, value must not exceed exp
      OP_IDLE,        // lim idle cycles
      OP_WAIT_IDLE,   // wait for busy_o low, data is the minimum busy time
      OP_WAIT_IRQ,    // wait for the next irq_lo_o pulse
      OP_EVENT_HI,    // one cycle pulse on event_hi_i
      OP_IRQ_HI       // irq_hi_o level against exp bit 0
   } op_e;

   typedef struct packed {
      op_e         op;
      reg_addr_t   addr;
      word_t       data;
      word_t       exp;
      int unsigned lim;
   } op_t;

   localparam int unsigned ResetCycles = 10;
   localparam int unsigned RefHalf     = 6;   // ref_clk_i half period in clocks
   localparam int unsigned ReadWait    = 4;
   localparam logic [31:0] Seed        = 32'h94df_96cc;

   // configuration masks
   localparam word_t BitReset  = word_t'(1) << CfgResetBit;
   localparam word_t BitIrq    = word_t'(1) << CfgIrqBit;
   localparam word_t BitIem    = word_t'(1) << CfgIemBit;
   localparam word_t BitCmpClr = word_t'(1) << CfgCmpClrBit;
   localparam word_t BitOs     = word_t'(1) << CfgOneShotBit;
   localparam word_t BitPresc  = word_t'(1) << CfgPrescEnBit;
   localparam word_t BitRef    = word_t'(1) << CfgRefClkEnBit;

   localparam word_t OsK   = 32'd10;
   localparam word_t PrK   = 32'd5;
   localparam word_t PrP   = 32'd3;
   localparam word_t EvK   = 32'd4;
   localparam word_t CcK   = 32'd6;
   localparam word_t PrCfg = BitOs | BitPresc | (PrP << CfgPrescLsb);
   localparam word_t EvCfg = BitRef | BitOs | BitIem | BitIrq;
   localparam word_t CcCfg = BitCmpClr | BitIrq;

   logic  clk_i;
   logic  rst_ni;
   logic  ref_clk_i;
   logic  req_i;
   word_t addr_i;
   logic  wen_i;
   word_t wdata_i;
   id_t   id_i;
   logic  event_lo_i;
   logic  event_hi_i;
   logic  r_valid_o;
   id_t   r_id_o;
   word_t r_rdata_o;
   logic  irq_lo_o;
   logic  irq_hi_o;
   logic  busy_o;

   op_t         ops[$];
   int unsigned budget     = 0;
   int unsigned max_cycles = 0;
   int unsigned cycle_cnt  = 0;

   timer_unit dut (.*);

   // **********************************************************************
   // clocks and timeout
   // **********************************************************************

   initial
   begin
      clk_i = 1'b0;
      forever
      begin
         #2 clk_i = ~clk_i;
      end
   end

   initial
   begin
      forever
      begin
         repeat (RefHalf) @(posedge clk_i);
         ref_clk_i <= ~ref_clk_i;
      end
   end

   always @(posedge clk_i)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= max_cycles)
      begin
         $display("ERROR at %0t: run did not finish within %0d cycles", $time, max_cycles);
         $display("Simulation failed");
         $fatal(1, "timeout");
      end
   end

   // **********************************************************************
   // error reporting and bus tasks
   // **********************************************************************

   task automatic report_mismatch(input string name, input word_t exp, input word_t got);
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
   endtask

   task automatic report_error(input string msg);
      $display("ERROR at %0t: %s", $time, msg);
      $display("Simulation failed");
      $fatal(1, "protocol error");
   endtask

   task automatic bus_write(input reg_addr_t addr, input word_t data);
      @(posedge clk_i);
      req_i   <= 1'b1;
      wen_i   <= 1'b0;
      addr_i  <= word_t'(addr);
      wdata_i <= data;
      @(posedge clk_i);
      req_i <= 1'b0;   // write lands on this edge
   endtask

   task automatic read_check(input reg_addr_t addr, input word_t exp, input logic at_most);
      id_t rid;
      int  n;
      rid = id_t'($urandom());
      n   = 0;
      @(posedge clk_i);
      req_i  <= 1'b1;
      wen_i  <= 1'b1;
      addr_i <= word_t'(addr);
      id_i   <= rid;
      @(posedge clk_i);
      req_i <= 1'b0;
      @(negedge clk_i);
      while (!r_valid_o && n < ReadWait)
      begin
         @(negedge clk_i);
         n++;
      end
      assert (r_valid_o) else report_error("no read response after the request");
      if (at_most)
      begin
         assert (r_rdata_o <= exp) else report_mismatch("r_rdata_o (bound)", exp, r_rdata_o);
      end
      else
      begin
         assert (r_rdata_o == exp) else report_mismatch("r_rdata_o", exp, r_rdata_o);
      end
      assert (r_id_o == rid) else report_mismatch("r_id_o", word_t'(rid), word_t'(r_id_o));
   endtask

   task automatic wait_busy_low(input word_t min_cycles, input int unsigned lim);
      int unsigned cycles;
      cycles = 0;
      @(negedge clk_i);
      while (busy_o && cycles < lim)
      begin
         cycles++;
         @(negedge clk_i);
      end
      assert (!busy_o) else report_error("busy_o stayed high too long");
      assert (cycles >= min_cycles)
      else report_mismatch("busy_o high cycles (min)", min_cycles, word_t'(cycles));
   endtask

   task automatic wait_irq_pulse(input int unsigned lim);
      int unsigned cycles;
      cycles = 0;
      @(negedge clk_i);
      while (irq_lo_o && cycles < lim)   // leave the current pulse first
      begin
         cycles++;
         @(negedge clk_i);
      end
      while (!irq_lo_o && cycles < lim)
      begin
         cycles++;
         @(negedge clk_i);
      end
      assert (irq_lo_o) else report_error("expected irq_lo_o pulse did not come");
   endtask

   task automatic check_irq_hi(input logic exp);
      @(negedge clk_i);
      assert (irq_hi_o == exp)
      else report_mismatch("irq_hi_o", word_t'(exp), word_t'(irq_hi_o));
   endtask

   task automatic pulse_event_hi();
      @(posedge clk_i);
      event_hi_i <= 1'b1;
      @(posedge clk_i);
      event_hi_i <= 1'b0;
   endtask

   // **********************************************************************
   // operation table
   // **********************************************************************

   task automatic add_op(input op_e op, input reg_addr_t addr, input word_t data,
                         input word_t exp, input int unsigned lim);
      ops.push_back('{op, addr, data, exp, lim});
      case (op)
         OP_WRITE, OP_EVENT_HI: budget += 2;
         OP_READ, OP_READ_MAX:  budget += 3 + ReadWait;
         OP_IDLE:               budget += lim;
         default:               budget += lim + 1;
      endcase
   endtask

   task automatic build_table();
      // registers, readback, unmapped offsets
      add_op(OP_WRITE,    AddrCmpLo,   32'h1234_5678, '0, 0);
      add_op(OP_WRITE,    AddrCmpHi,   32'h8765_4321, '0, 0);
      add_op(OP_WRITE,    AddrCfgLo,   32'h0000_5A74, '0, 0);
      add_op(OP_WRITE,    AddrCfgHi,   32'h0000_3C98, '0, 0);
      add_op(OP_WRITE,    AddrValLo,   32'h0000_0100, '0, 0);
      add_op(OP_WRITE,    AddrValHi,   32'h0000_0ABC, '0, 0);
      add_op(OP_READ,     AddrCfgLo,   '0, 32'h0000_5A74, 0);
      add_op(OP_READ,     AddrCfgHi,   '0, 32'h0000_3C98, 0);
      add_op(OP_READ,     AddrCmpLo,   '0, 32'h1234_5678, 0);
      add_op(OP_READ,     AddrCmpHi,   '0, 32'h8765_4321, 0);
      add_op(OP_READ,     AddrValLo,   '0, 32'h0000_0100, 0);
      add_op(OP_READ,     AddrValHi,   '0, 32'h0000_0ABC, 0);
      add_op(OP_READ,     6'h28,       '0, '0, 0);
      add_op(OP_READ,     AddrStartLo, '0, '0, 0);
      add_op(OP_WRITE,    AddrCfgLo,   '0, '0, 0);
      add_op(OP_WRITE,    AddrCfgHi,   '0, '0, 0);
      // one-shot on system clocks
      add_op(OP_WRITE,    AddrCmpLo,   OsK, '0, 0);
      add_op(OP_WRITE,    AddrCfgLo,   BitOs, '0, 0);
      add_op(OP_WRITE,    AddrResetLo, '0, '0, 0);
      add_op(OP_WRITE,    AddrStartLo, '0, '0, 0);
      add_op(OP_WAIT_IDLE, '0,         OsK, '0, OsK + 8);
      add_op(OP_READ,     AddrValLo,   '0, OsK, 0);
      add_op(OP_READ,     AddrCfgLo,   '0, BitOs, 0);
      // prescaler, K*(P+1) clocks to reach compare
      add_op(OP_WRITE,    AddrCfgLo,   PrCfg, '0, 0);
      add_op(OP_WRITE,    AddrCmpLo,   PrK, '0, 0);
      add_op(OP_WRITE,    AddrResetLo, '0, '0, 0);
      add_op(OP_WRITE,    AddrStartLo, '0, '0, 0);
      add_op(OP_WAIT_IDLE, '0,         PrK * (PrP + 1), '0, PrK * (PrP + 1) + 8);
      add_op(OP_READ,     AddrValLo,   '0, PrK, 0);
      add_op(OP_READ,     AddrCfgLo,   '0, PrCfg, 0);
      // hi started by its event, counting reference edges
      add_op(OP_WRITE,    AddrResetHi, '0, '0, 0);
      add_op(OP_WRITE,    AddrCmpHi,   EvK, '0, 0);
      add_op(OP_WRITE,    AddrCfgHi,   EvCfg, '0, 0);
      add_op(OP_IRQ_HI,   '0,          '0, '0, 0);   // counter still below compare
      add_op(OP_EVENT_HI, '0,          '0, '0, 0);
      add_op(OP_WAIT_IDLE, '0, (EvK - 1) * 2 * RefHalf, '0, (EvK + 2) * 2 * RefHalf);
      add_op(OP_READ,     AddrValHi,   '0, EvK, 0);
      add_op(OP_READ,     AddrCfgHi,   '0, EvCfg, 0);
      add_op(OP_IRQ_HI,   '0,          '0, 32'd1, 0);   // parked on compare, irq on
      // compare and clear with irq on lo
      add_op(OP_WRITE,    AddrCfgLo,   '0, '0, 0);
      add_op(OP_WRITE,    AddrResetLo, '0, '0, 0);
      add_op(OP_WRITE,    AddrCmpLo,   CcK, '0, 0);
      add_op(OP_WRITE,    AddrCfgLo,   CcCfg, '0, 0);
      add_op(OP_WRITE,    AddrStartLo, '0, '0, 0);
      add_op(OP_WAIT_IRQ, '0,          '0, '0, 4 * CcK);
      add_op(OP_WAIT_IRQ, '0,          '0, '0, 4 * CcK);
      add_op(OP_READ_MAX, AddrValLo,   '0, CcK, 0);
      add_op(OP_IDLE,     '0,          '0, '0, 3);
      add_op(OP_READ_MAX, AddrValLo,   '0, CcK, 0);
      add_op(OP_IDLE,     '0,          '0, '0, 2);
      add_op(OP_READ_MAX, AddrValLo,   '0, CcK, 0);
      add_op(OP_WRITE,    AddrCfgLo,   '0, '0, 0);
      add_op(OP_WAIT_IDLE, '0,         '0, '0, 4);
      // reset command and the self clearing reset bit
      add_op(OP_WRITE,    AddrValLo,   32'h0000_0055, '0, 0);
      add_op(OP_READ,     AddrValLo,   '0, 32'h0000_0055, 0);
      add_op(OP_WRITE,    AddrResetLo, '0, '0, 0);
      add_op(OP_READ,     AddrValLo,   '0, '0, 0);
      add_op(OP_WRITE,    AddrValHi,   32'h0000_0077, '0, 0);
      add_op(OP_READ,     AddrValHi,   '0, 32'h0000_0077, 0);
      add_op(OP_WRITE,    AddrCfgHi,   BitReset, '0, 0);
      add_op(OP_READ,     AddrValHi,   '0, '0, 0);
      add_op(OP_READ,     AddrCfgHi,   '0, '0, 0);
      add_op(OP_IRQ_HI,   '0,          '0, '0, 0);
      max_cycles = 2 * (budget + ResetCycles);
   endtask

   initial
   begin
      rst_ni     = 1'b0;
      ref_clk_i  = 1'b0;
      req_i      = 1'b0;
      addr_i     = '0;
      wen_i      = 1'b0;
      wdata_i    = '0;
      id_i       = '0;
      event_lo_i = 1'b0;
      event_hi_i = 1'b0;
      void'($urandom(Seed));
      build_table();
      repeat (ResetCycles) @(posedge clk_i);
      rst_ni <= 1'b1;
      foreach (ops[i])
      begin
         case (ops[i].op)
            OP_WRITE:     bus_write(ops[i].addr, ops[i].data);
            OP_READ:      read_check(ops[i].addr, ops[i].exp, 1'b0);
            OP_READ_MAX:  read_check(ops[i].addr, ops[i].exp, 1'b1);
            OP_IDLE:      repeat (ops[i].lim) @(posedge clk_i);
            OP_WAIT_IDLE: wait_busy_low(ops[i].data, ops[i].lim);
            OP_WAIT_IRQ:  wait_irq_pulse(ops[i].lim);
            OP_IRQ_HI:    check_irq_hi(ops[i].exp[0]);
            default:      pulse_event_hi();
         endcase
      end
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

/* timer_assertions.sv */
module timer_assertions import timer_pkg::*; (
   input logic  clk_i,
   input logic  rst_ni,
   input logic  req_i,
   input logic  r_valid_i,
   input logic  irq_hi_i,
   input logic  busy_i,
   input word_t cfg_hi_i,
   input word_t cmp_hi_i,
   input word_t val_hi_i
);

   // one response per request, exactly one cycle later
   valid_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      req_i |=> r_valid_i)
   else $error("r_valid_o missing after a request");

   no_valid_without_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !req_i |=> !r_valid_i)
   else $error("r_valid_o without a request");

   irq_hi_on_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
      irq_hi_i |-> (val_hi_i == cmp_hi_i) && cfg_hi_i[CfgIrqBit])
   else $error("irq_hi_o high without a hi compare match");

   // async reset must hold every channel stopped
   idle_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !busy_i)
   else $error("busy_o high during reset");

endmodule

bind timer_unit timer_assertions u_assertions (
   .clk_i     (clk_i),
   .rst_ni    (rst_ni),
   .req_i     (req_i),
   .r_valid_i (r_valid_o),
   .irq_hi_i  (irq_hi_o),
   .busy_i    (busy_o),
   .cfg_hi_i  (cfg_hi),
   .cmp_hi_i  (cmp_hi),
   .val_hi_i  (val_hi)
);

/* timer_bus.sv */
module timer_bus import timer_pkg::*; (
   input  logic  clk_i,
   input  logic  rst_ni,
   input  logic  req_i,
   input  logic  wen_i,          // high reads, low writes
   input  word_t addr_i,
   input  word_t wdata_i,
   input  id_t   id_i,
   input  word_t cfg_lo_i,
   input  word_t cmp_lo_i,
   input  word_t val_lo_i,
   input  word_t cfg_hi_i,
   input  word_t cmp_hi_i,
   input  word_t val_hi_i,
   input  logic  enabled_lo_i,
   input  logic  enabled_hi_i,
   output logic  cfg_we_lo_o,
   output logic  cmp_we_lo_o,
   output logic  val_we_lo_o,
   output logic  start_lo_o,
   output logic  clear_lo_o,
   output logic  cfg_we_hi_o,
   output logic  cmp_we_hi_o,
   output logic  val_we_hi_o,
   output logic  start_hi_o,
   output logic  clear_hi_o,
   output word_t wdata_o,
   output logic  r_valid_o,
   output id_t   r_id_o,
   output word_t r_rdata_o,
   output logic  busy_o
);

   bus_state_e state_q;
   bus_state_e state_d;
   reg_addr_t  wr_addr;
   reg_addr_t  addr_q;
   logic       wr_en;
   logic       rd_q;

   // *************************************************************************
   // response FSM and request capture
   // *************************************************************************

   assign state_d   = req_i ? BUS_RUN : BUS_IDLE;   // every request is taken
   assign r_valid_o = (state_q == BUS_RUN);

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q <= BUS_IDLE;
         rd_q    <= 1'b0;
         addr_q  <= '0;
         r_id_o  <= '0;
      end
      else
      begin
         state_q <= state_d;
         rd_q    <= req_i & wen_i;
         addr_q  <= addr_i[$bits(reg_addr_t)-1:0];
         r_id_o  <= id_i;
      end
   end

   // *************************************************************************
   // write decode
   // *************************************************************************

   assign wr_en   = req_i & ~wen_i;
   assign wr_addr = addr_i[$bits(reg_addr_t)-1:0];
   assign wdata_o = wdata_i;

   always_comb
   begin
      cfg_we_lo_o = 1'b0;
      cmp_we_lo_o = 1'b0;
      val_we_lo_o = 1'b0;
      start_lo_o  = 1'b0;
      clear_lo_o  = 1'b0;
      cfg_we_hi_o = 1'b0;
      cmp_we_hi_o = 1'b0;
      val_we_hi_o = 1'b0;
      start_hi_o  = 1'b0;
      clear_hi_o  = 1'b0;
      if (wr_en)
      begin
         case (wr_addr)
            AddrCfgLo:   cfg_we_lo_o = 1'b1;
            AddrCfgHi:   cfg_we_hi_o = 1'b1;
            AddrValLo:   val_we_lo_o = 1'b1;
            AddrValHi:   val_we_hi_o = 1'b1;
            AddrCmpLo:   cmp_we_lo_o = 1'b1;
            AddrCmpHi:   cmp_we_hi_o = 1'b1;
            AddrStartLo: start_lo_o  = 1'b1;
            AddrStartHi: start_hi_o  = 1'b1;
            AddrResetLo: clear_lo_o  = 1'b1;
            AddrResetHi: clear_hi_o  = 1'b1;
            default:     ;   // unmapped writes are dropped
         endcase
      end
   end

   // read data shows the live register value in the response cycle
   always_comb
   begin
      r_rdata_o = '0;
      if (rd_q)
      begin
         case (addr_q)
            AddrCfgLo: r_rdata_o = cfg_lo_i;
            AddrCfgHi: r_rdata_o = cfg_hi_i;
            AddrValLo: r_rdata_o = val_lo_i;
            AddrValHi: r_rdata_o = val_hi_i;
            AddrCmpLo: r_rdata_o = cmp_lo_i;
            AddrCmpHi: r_rdata_o = cmp_hi_i;
            default:   r_rdata_o = '0;
         endcase
      end
   end

   assign busy_o = enabled_lo_i | enabled_hi_i;

endmodule

/* timer_channel.sv */
module timer_channel import timer_pkg::*; (
   input  logic  clk_i,
   input  logic  rst_ni,
   input  logic  cfg_we_i,
   input  logic  cmp_we_i,
   input  logic  val_we_i,
   input  logic  start_i,
   input  logic  clear_i,
   input  logic  event_i,
   input  logic  ref_edge_i,
   input  word_t wdata_i,
   output word_t cfg_o,
   output word_t cmp_o,
   output word_t val_o,
   output logic  irq_o,
   output logic  enabled_o
);

   word_t  cfg_q;
   word_t  cfg_d;
   word_t  cmp_q;
   word_t  count_value;
   presc_t presc_limit;
   logic   count_match;
   logic   presc_match;
   logic   start_req;
   logic   stop_hit;
   logic   soft_clear;
   logic   fire;
   logic   presc_clear;
   logic   presc_incr;
   logic   count_clear;
   logic   count_incr;

   // *************************************************************************
   // configuration and compare registers
   // *************************************************************************

   assign start_req  = start_i | (event_i & cfg_q[CfgIemBit]);
   assign stop_hit   = cfg_q[CfgOneShotBit] & count_match;   // one-shot end of run
   assign soft_clear = clear_i | cfg_q[CfgResetBit];

   always_comb
   begin
      cfg_d = cfg_q;
      if (cfg_we_i)
      begin
         cfg_d = wdata_i;
      end
      if (cfg_q[CfgResetBit])
      begin
         cfg_d[CfgResetBit] = 1'b0;   // acted on this cycle, drop it
      end
      // start and event beat one-shot, both beat the bus write
      if (start_req)
      begin
         cfg_d[CfgEnableBit] = 1'b1;
      end
      else if (stop_hit)
      begin
         cfg_d[CfgEnableBit] = 1'b0;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         cfg_q <= '0;
         cmp_q <= '0;
      end
      else
      begin
         cfg_q <= cfg_d;
         if (cmp_we_i)
         begin
            cmp_q <= wdata_i;
         end
      end
   end

   // *************************************************************************
   // count source, prescaler and main counter
   // *************************************************************************

   // hold still on the compare value once a one-shot run is done
   assign fire = cfg_q[CfgEnableBit] & ~stop_hit & (~cfg_q[CfgRefClkEnBit] | ref_edge_i);

   assign presc_limit = cfg_q[CfgPrescMsb:CfgPrescLsb];
   assign presc_incr  = fire & cfg_q[CfgPrescEnBit] & ~presc_match;
   assign presc_clear = soft_clear | ~cfg_q[CfgPrescEnBit] | (fire & presc_match);

   assign count_incr  = fire & (~cfg_q[CfgPrescEnBit] | presc_match);
   assign count_clear = soft_clear | (cfg_q[CfgCmpClrBit] & count_match);

   timer_counter #(
      .Width (PrescWidth)
   ) u_presc (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .clear_i      (presc_clear),
      .load_i       (1'b0),
      .load_value_i ('0),
      .incr_i       (presc_incr),
      .compare_i    (presc_limit),
      .value_o      (),
      .match_o      (presc_match)
   );

   timer_counter #(
      .Width (WordWidth)
   ) u_count (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .clear_i      (count_clear),
      .load_i       (val_we_i),
      .load_value_i (wdata_i),
      .incr_i       (count_incr),
      .compare_i    (cmp_q),
      .value_o      (count_value),
      .match_o      (count_match)
   );

   assign irq_o     = count_match & cfg_q[CfgIrqBit];   // level while at compare
   assign enabled_o = cfg_q[CfgEnableBit];
   assign cfg_o     = cfg_q;
   assign cmp_o     = cmp_q;
   assign val_o     = count_value;

endmodule

/* timer_counter.sv */
module timer_counter #(
   parameter int unsigned Width = 32
) (
   input  logic             clk_i,
   input  logic             rst_ni,
   input  logic             clear_i,
   input  logic             load_i,
   input  logic [Width-1:0] load_value_i,
   input  logic             incr_i,
   input  logic [Width-1:0] compare_i,
   output logic [Width-1:0] value_o,
   output logic             match_o
);

   logic [Width-1:0] count_q;

   // clear wins over load, load wins over increment
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         count_q <= '0;
      end
      else if (clear_i)
      begin
         count_q <= '0;
      end
      else if (load_i)
      begin
         count_q <= load_value_i;
      end
      else if (incr_i)
      begin
         count_q <= count_q + 1'b1;   // wraps at all ones
      end
   end

   assign value_o = count_q;
   assign match_o = (count_q == compare_i);   // registered value against compare

endmodule

/* timer_pkg.sv */
package timer_pkg;

   localparam int unsigned IdWidth    = 5;
   localparam int unsigned WordWidth  = 32;
   localparam int unsigned PrescWidth = 8;

   typedef logic [WordWidth-1:0]  word_t;
   typedef logic [5:0]            reg_addr_t;   // low address bits only
   typedef logic [PrescWidth-1:0] presc_t;
   typedef logic [IdWidth-1:0]    id_t;

   // register map
   localparam reg_addr_t AddrCfgLo   = 6'h00;
   localparam reg_addr_t AddrCfgHi   = 6'h04;
   localparam reg_addr_t AddrValLo   = 6'h08;
   localparam reg_addr_t AddrValHi   = 6'h0C;
   localparam reg_addr_t AddrCmpLo   = 6'h10;
   localparam reg_addr_t AddrCmpHi   = 6'h14;
   localparam reg_addr_t AddrStartLo = 6'h18;   // write only
   localparam reg_addr_t AddrStartHi = 6'h1C;
   localparam reg_addr_t AddrResetLo = 6'h20;   // write only
   localparam reg_addr_t AddrResetHi = 6'h24;

   // configuration word fields
   localparam int unsigned CfgEnableBit   = 0;
   localparam int unsigned CfgResetBit    = 1;   // self clearing
   localparam int unsigned CfgIrqBit      = 2;
   localparam int unsigned CfgIemBit      = 3;
   localparam int unsigned CfgCmpClrBit   = 4;
   localparam int unsigned CfgOneShotBit  = 5;
   localparam int unsigned CfgPrescEnBit  = 6;
   localparam int unsigned CfgRefClkEnBit = 7;
   localparam int unsigned CfgPrescLsb    = 8;
   localparam int unsigned CfgPrescMsb    = 15;

   typedef enum logic {
      BUS_IDLE,
      BUS_RUN
   } bus_state_e;

endpackage

/* timer_ref_sync.sv */
module timer_ref_sync (
   input  logic clk_i,
   input  logic rst_ni,
   input  logic ref_clk_i,
   output logic ref_edge_o
);

   logic sync1_q;
   logic sync2_q;
   logic prev_q;

   // two stage synchronizer, then one flop of history for the edge
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         sync1_q <= 1'b0;
         sync2_q <= 1'b0;
         prev_q  <= 1'b0;
      end
      else
      begin
         sync1_q <= ref_clk_i;
         sync2_q <= sync1_q;
         prev_q  <= sync2_q;
      end
   end

   assign ref_edge_o = sync2_q & ~prev_q;   // one clock per rising edge

endmodule

/* timer_unit.sv */
module timer_unit import timer_pkg::*; (
   input  logic  clk_i,
   input  logic  rst_ni,
   input  logic  ref_clk_i,
   input  logic  req_i,
   input  word_t addr_i,
   input  logic  wen_i,
   input  word_t wdata_i,
   input  id_t   id_i,
   input  logic  event_lo_i,
   input  logic  event_hi_i,
   output logic  r_valid_o,
   output id_t   r_id_o,
   output word_t r_rdata_o,
   output logic  irq_lo_o,
   output logic  irq_hi_o,
   output logic  busy_o
);

   word_t wdata;
   word_t cfg_lo, cmp_lo, val_lo;
   word_t cfg_hi, cmp_hi, val_hi;
   logic  cfg_we_lo, cmp_we_lo, val_we_lo, start_lo, clear_lo;
   logic  cfg_we_hi, cmp_we_hi, val_we_hi, start_hi, clear_hi;
   logic  enabled_lo, enabled_hi;
   logic  ref_edge;   // shared by both channels

   timer_bus u_bus (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .req_i        (req_i),
      .wen_i        (wen_i),
      .addr_i       (addr_i),
      .wdata_i      (wdata_i),
      .id_i         (id_i),
      .cfg_lo_i     (cfg_lo),
      .cmp_lo_i     (cmp_lo),
      .val_lo_i     (val_lo),
      .cfg_hi_i     (cfg_hi),
      .cmp_hi_i     (cmp_hi),
      .val_hi_i     (val_hi),
      .enabled_lo_i (enabled_lo),
      .enabled_hi_i (enabled_hi),
      .cfg_we_lo_o  (cfg_we_lo),
      .cmp_we_lo_o  (cmp_we_lo),
      .val_we_lo_o  (val_we_lo),
      .start_lo_o   (start_lo),
      .clear_lo_o   (clear_lo),
      .cfg_we_hi_o  (cfg_we_hi),
      .cmp_we_hi_o  (cmp_we_hi),
      .val_we_hi_o  (val_we_hi),
      .start_hi_o   (start_hi),
      .clear_hi_o   (clear_hi),
      .wdata_o      (wdata),
      .r_valid_o    (r_valid_o),
      .r_id_o       (r_id_o),
      .r_rdata_o    (r_rdata_o),
      .busy_o       (busy_o)
   );

   timer_ref_sync u_ref_sync (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .ref_clk_i  (ref_clk_i),
      .ref_edge_o (ref_edge)
   );

   timer_channel u_lo (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .cfg_we_i   (cfg_we_lo),
      .cmp_we_i   (cmp_we_lo),
      .val_we_i   (val_we_lo),
      .start_i    (start_lo),
      .clear_i    (clear_lo),
      .event_i    (event_lo_i),
      .ref_edge_i (ref_edge),
      .wdata_i    (wdata),
      .cfg_o      (cfg_lo),
      .cmp_o      (cmp_lo),
      .val_o      (val_lo),
      .irq_o      (irq_lo_o),
      .enabled_o  (enabled_lo)
   );

   timer_channel u_hi (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .cfg_we_i   (cfg_we_hi),
      .cmp_we_i   (cmp_we_hi),
      .val_we_i   (val_we_hi),
      .start_i    (start_hi),
      .clear_i    (clear_hi),
      .event_i    (event_hi_i),
      .ref_edge_i (ref_edge),
      .wdata_i    (wdata),
      .cfg_o      (cfg_hi),
      .cmp_o      (cmp_hi),
      .val_o      (val_hi),
      .irq_o      (irq_hi_o),
      .enabled_o  (enabled_hi)
   );

endmodule
